/* hdl/tcp_tx_pkg.sv */
`default_nettype none

package tcp_tx_pkg;

    typedef logic [31:0] seq_t;
    typedef logic [15:0] port_t;
    typedef logic [15:0] len_t;
    typedef logic [7:0]  flags_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  addr_t;

    typedef enum logic [1:0] {
        SEG_SYN  = 2'd0,
        SEG_ACK  = 2'd1,
        SEG_FIN  = 2'd2,
        SEG_DATA = 2'd3
    } seg_kind_e;

    // host command, never SEG_DATA
    typedef struct packed {
        seg_kind_e kind;
    } tx_cmd_t;

    typedef struct packed {
        port_t  src_port;
        port_t  dst_port;
        seq_t   seq;
        seq_t   ack;
        flags_t flags;
        len_t   window;
        len_t   ip_len;
        logic   has_payload;
    } tcp_hdr_t;

    typedef struct packed {
        port_t src_port;
        port_t dst_port;
        seq_t  ack;
        len_t  window;
    } conn_cfg_t;

    // ####################################################################
    // tcp flag bits
    // ####################################################################
    localparam flags_t FLAG_FIN = 8'h01;
    localparam flags_t FLAG_SYN = 8'h02;
    localparam flags_t FLAG_RST = 8'h04;
    localparam flags_t FLAG_PSH = 8'h08;
    localparam flags_t FLAG_ACK = 8'h10;
    localparam flags_t FLAG_URG = 8'h20;
    localparam flags_t FLAG_ECE = 8'h40;
    localparam flags_t FLAG_CWR = 8'h80;

    localparam int   HDR_WORDS      = 5;
    // ip header plus tcp header, no options
    localparam len_t IP_TCP_HDR_LEN = 16'd40;

    // register map
    localparam addr_t REG_CMD    = 8'h00;
    localparam addr_t REG_PORTS  = 8'h04;
    localparam addr_t REG_ACK    = 8'h08;
    localparam addr_t REG_WINDOW = 8'h0C;
    localparam addr_t REG_SEQ    = 8'h10;
    localparam addr_t REG_STATUS = 8'h14;

endpackage

`default_nettype wire

/* hdl/tcp_cmd_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module tcp_cmd_decode (
    input  wire                   i_clk,
    input  wire                   i_rst,

    input  tcp_tx_pkg::addr_t     i_awaddr,
    input  wire                   i_awvalid,
    output logic                  o_awready,
    input  tcp_tx_pkg::word_t     i_wdata,
    input  wire                   i_wvalid,
    output logic                  o_wready,
    output logic                  o_bvalid,
    input  wire                   i_bready,
    input  tcp_tx_pkg::addr_t     i_araddr,
    input  wire                   i_arvalid,
    output logic                  o_arready,
    output tcp_tx_pkg::word_t     o_rdata,
    output logic                  o_rvalid,
    input  wire                   i_rready,

    output tcp_tx_pkg::conn_cfg_t o_cfg,
    output tcp_tx_pkg::tx_cmd_t   o_cmd,
    output logic                  o_cmd_valid,
    input  wire                   i_cmd_ready,
    input  tcp_tx_pkg::seq_t      i_seq,
    input  wire                   i_busy
);

    logic              wr_hs;
    logic              rd_hs;
    logic              cmd_post;
    tcp_tx_pkg::word_t rd_mux;

    // ####################################################################
    // write channel
    // ####################################################################

    // address and data taken together, one write outstanding
    assign wr_hs     = i_awvalid && i_wvalid && !o_bvalid && !o_cmd_valid;
    assign o_awready = wr_hs;
    assign o_wready  = wr_hs;

    // values above 2 are not a command
    assign cmd_post = wr_hs && (i_awaddr == tcp_tx_pkg::REG_CMD) && (i_wdata < 32'd3);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_bvalid    <= 1'b0;
            o_cmd_valid <= 1'b0;
            o_cfg       <= '0;
        end else begin
            if (wr_hs) begin
                o_bvalid <= 1'b1;
            end else if (i_bready) begin
                o_bvalid <= 1'b0;
            end

            if (cmd_post) begin
                o_cmd_valid <= 1'b1;
            end else if (i_cmd_ready) begin
                o_cmd_valid <= 1'b0;
            end

            if (wr_hs) begin
                case (i_awaddr)
                    tcp_tx_pkg::REG_PORTS: begin
                        o_cfg.src_port <= i_wdata[31:16];
                        o_cfg.dst_port <= i_wdata[15:0];
                    end
                    tcp_tx_pkg::REG_ACK: begin
                        o_cfg.ack <= i_wdata;
                    end
                    tcp_tx_pkg::REG_WINDOW: begin
                        o_cfg.window <= i_wdata[15:0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (cmd_post) begin
            o_cmd.kind <= tcp_tx_pkg::seg_kind_e'(i_wdata[1:0]);
        end
    end

    // ####################################################################
    // read channel
    // ####################################################################
    assign o_arready = !o_rvalid;
    assign rd_hs     = i_arvalid && o_arready;

    always_comb begin
        rd_mux = '0;
        case (i_araddr)
            tcp_tx_pkg::REG_PORTS:  rd_mux = {o_cfg.src_port, o_cfg.dst_port};
            tcp_tx_pkg::REG_ACK:    rd_mux = o_cfg.ack;
            tcp_tx_pkg::REG_WINDOW: rd_mux = {16'd0, o_cfg.window};
            tcp_tx_pkg::REG_SEQ:    rd_mux = i_seq;
            tcp_tx_pkg::REG_STATUS: rd_mux = {31'd0, i_busy};
            default:                rd_mux = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_rvalid <= 1'b0;
        end else if (rd_hs) begin
            o_rvalid <= 1'b1;
        end else if (i_rready) begin
            o_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd_hs) begin
            o_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

/* hdl/tcp_tx_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module tcp_tx_ctrl (
    input  wire                   i_clk,
    input  wire                   i_rst,

    input  tcp_tx_pkg::conn_cfg_t i_cfg,
    input  tcp_tx_pkg::tx_cmd_t   i_cmd,
    input  wire                   i_cmd_valid,
    output logic                  o_cmd_ready,

    input  wire                   i_s_valid,
    input  tcp_tx_pkg::len_t      i_s_len,

    output tcp_tx_pkg::tcp_hdr_t  o_hdr,
    output logic                  o_hdr_valid,
    input  wire                   i_hdr_ready,
    input  wire                   i_seg_done,

    output tcp_tx_pkg::seq_t      o_seq,
    output logic                  o_busy
);

    typedef enum logic [2:0] {
        IDLE,
        SEND_SYN,
        SEND_ACK,
        SEND_FIN,
        SEND_DATA
    } state_e;

    state_e             state;
    state_e             state_next;
    logic               hdr_pending;
    tcp_tx_pkg::len_t   seg_len;
    tcp_tx_pkg::len_t   seq_inc;
    tcp_tx_pkg::flags_t flags;

    assign o_cmd_ready = (state == IDLE);
    assign o_busy      = (state != IDLE);
    assign o_hdr_valid = hdr_pending;

    // ####################################################################
    // next state
    // ####################################################################
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                // host command ahead of a waiting payload
                if (i_cmd_valid) begin
                    case (i_cmd.kind)
                        tcp_tx_pkg::SEG_SYN: state_next = SEND_SYN;
                        tcp_tx_pkg::SEG_ACK: state_next = SEND_ACK;
                        tcp_tx_pkg::SEG_FIN: state_next = SEND_FIN;
                        default:             state_next = IDLE;
                    endcase
                end else if (i_s_valid) begin
                    state_next = SEND_DATA;
                end
            end
            default: begin
                if (i_seg_done) begin
                    state_next = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state       <= IDLE;
            hdr_pending <= 1'b0;
            o_seq       <= '0;
        end else begin
            state <= state_next;
            if (state == IDLE && state_next != IDLE) begin
                hdr_pending <= 1'b1;
            end else if (i_hdr_ready) begin
                hdr_pending <= 1'b0;
            end
            if (state != IDLE && i_seg_done) begin
                o_seq <= o_seq + tcp_tx_pkg::seq_t'(seq_inc);
            end
        end
    end

    // length sideband is stable from the first beat
    always_ff @(posedge i_clk) begin
        if (state == IDLE) begin
            seg_len <= i_s_len;
        end
    end

    // ####################################################################
    // header fields
    // ####################################################################
    always_comb begin
        flags   = tcp_tx_pkg::FLAG_ACK;
        seq_inc = '0;
        case (state)
            SEND_SYN: begin
                flags   = tcp_tx_pkg::FLAG_SYN;
                seq_inc = 16'd1;
            end
            SEND_FIN: begin
                flags   = tcp_tx_pkg::FLAG_FIN | tcp_tx_pkg::FLAG_ACK;
                seq_inc = 16'd1;
            end
            SEND_DATA: begin
                flags   = tcp_tx_pkg::FLAG_PSH | tcp_tx_pkg::FLAG_ACK;
                seq_inc = seg_len;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        o_hdr.src_port    = i_cfg.src_port;
        o_hdr.dst_port    = i_cfg.dst_port;
        o_hdr.seq         = o_seq;
        o_hdr.ack         = i_cfg.ack;
        o_hdr.flags       = flags;
        o_hdr.window      = i_cfg.window;
        o_hdr.has_payload = (state == SEND_DATA);
        if (state == SEND_DATA) begin
            o_hdr.ip_len = tcp_tx_pkg::IP_TCP_HDR_LEN + seg_len;
        end else begin
            o_hdr.ip_len = tcp_tx_pkg::IP_TCP_HDR_LEN;
        end
    end

endmodule

`default_nettype wire

/* hdl/tcp_seg_builder.sv */
`timescale 1ns/1ns
`default_nettype none

module tcp_seg_builder (
    input  wire                  i_clk,
    input  wire                  i_rst,

    input  tcp_tx_pkg::tcp_hdr_t i_hdr,
    input  wire                  i_hdr_valid,
    output logic                 o_hdr_ready,

    input  tcp_tx_pkg::word_t    i_s_data,
    input  wire [3:0]            i_s_keep,
    input  wire                  i_s_valid,
    output logic                 o_s_ready,
    input  wire                  i_s_last,

    output tcp_tx_pkg::word_t    o_m_data,
    output logic [3:0]           o_m_keep,
    output logic                 o_m_valid,
    input  wire                  i_m_ready,
    output logic                 o_m_last,

    output tcp_tx_pkg::len_t     o_ip_len,
    output logic                 o_seg_done
);

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        PAYLOAD
    } state_e;

    state_e               state;
    tcp_tx_pkg::tcp_hdr_t hdr_q;
    logic [2:0]           word_idx;
    logic                 hdr_last;
    tcp_tx_pkg::word_t    hdr_word;

    assign o_hdr_ready = (state == IDLE);
    assign o_ip_len    = hdr_q.ip_len;
    assign hdr_last    = (word_idx == 3'(tcp_tx_pkg::HDR_WORDS - 1));

    always_ff @(posedge i_clk) begin
        if (i_hdr_valid && o_hdr_ready) begin
            hdr_q <= i_hdr;
        end
    end

    // standard tcp layout, checksum left for the ip stage
    always_comb begin
        case (word_idx)
            3'd0:    hdr_word = {hdr_q.src_port, hdr_q.dst_port};
            3'd1:    hdr_word = hdr_q.seq;
            3'd2:    hdr_word = hdr_q.ack;
            3'd3:    hdr_word = {4'd5, 4'd0, hdr_q.flags, hdr_q.window};
            default: hdr_word = '0;
        endcase
    end

    // ####################################################################
    // output mux
    // ####################################################################
    always_comb begin
        o_m_data   = hdr_word;
        o_m_keep   = 4'hf;
        o_m_valid  = 1'b0;
        o_m_last   = 1'b0;
        o_s_ready  = 1'b0;
        o_seg_done = 1'b0;
        case (state)
            HEADER: begin
                o_m_valid  = 1'b1;
                o_m_last   = hdr_last && !hdr_q.has_payload;
                o_seg_done = o_m_last && i_m_ready;
            end
            PAYLOAD: begin
                o_m_data   = i_s_data;
                o_m_keep   = i_s_keep;
                o_m_valid  = i_s_valid;
                o_m_last   = i_s_last;
                o_s_ready  = i_m_ready;
                o_seg_done = i_s_valid && i_s_last && i_m_ready;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= IDLE;
            word_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    word_idx <= '0;
                    if (i_hdr_valid) begin
                        state <= HEADER;
                    end
                end
                HEADER: begin
                    if (i_m_ready) begin
                        word_idx <= word_idx + 3'd1;
                        if (hdr_last) begin
                            state <= hdr_q.has_payload ? PAYLOAD : IDLE;
                        end
                    end
                end
                PAYLOAD: begin
                    if (o_seg_done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/tcp_tx_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tcp_tx_top (
    input  wire               i_clk,
    input  wire               i_rst,

    // register port
    input  tcp_tx_pkg::addr_t i_awaddr,
    input  wire               i_awvalid,
    output logic              o_awready,
    input  tcp_tx_pkg::word_t i_wdata,
    input  wire               i_wvalid,
    output logic              o_wready,
    output logic              o_bvalid,
    input  wire               i_bready,
    input  tcp_tx_pkg::addr_t i_araddr,
    input  wire               i_arvalid,
    output logic              o_arready,
    output tcp_tx_pkg::word_t o_rdata,
    output logic              o_rvalid,
    input  wire               i_rready,

    // payload in
    input  tcp_tx_pkg::word_t i_s_data,
    input  wire [3:0]         i_s_keep,
    input  wire               i_s_valid,
    output logic              o_s_ready,
    input  wire               i_s_last,
    input  tcp_tx_pkg::len_t  i_s_len,

    // segment out
    output tcp_tx_pkg::word_t o_m_data,
    output logic [3:0]        o_m_keep,
    output logic              o_m_valid,
    input  wire               i_m_ready,
    output logic              o_m_last,
    output tcp_tx_pkg::len_t  o_ip_len
);

    tcp_tx_pkg::conn_cfg_t cfg;
    tcp_tx_pkg::tx_cmd_t   cmd;
    logic                  cmd_valid;
    logic                  cmd_ready;
    tcp_tx_pkg::seq_t      seq;
    logic                  busy;
    tcp_tx_pkg::tcp_hdr_t  hdr;
    logic                  hdr_valid;
    logic                  hdr_ready;
    logic                  seg_done;

    tcp_cmd_decode u_tcp_cmd_decode (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_awaddr    (i_awaddr),
        .i_awvalid   (i_awvalid),
        .o_awready   (o_awready),
        .i_wdata     (i_wdata),
        .i_wvalid    (i_wvalid),
        .o_wready    (o_wready),
        .o_bvalid    (o_bvalid),
        .i_bready    (i_bready),
        .i_araddr    (i_araddr),
        .i_arvalid   (i_arvalid),
        .o_arready   (o_arready),
        .o_rdata     (o_rdata),
        .o_rvalid    (o_rvalid),
        .i_rready    (i_rready),
        .o_cfg       (cfg),
        .o_cmd       (cmd),
        .o_cmd_valid (cmd_valid),
        .i_cmd_ready (cmd_ready),
        .i_seq       (seq),
        .i_busy      (busy)
    );

    tcp_tx_ctrl u_tcp_tx_ctrl (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_cfg       (cfg),
        .i_cmd       (cmd),
        .i_cmd_valid (cmd_valid),
        .o_cmd_ready (cmd_ready),
        .i_s_valid   (i_s_valid),
        .i_s_len     (i_s_len),
        .o_hdr       (hdr),
        .o_hdr_valid (hdr_valid),
        .i_hdr_ready (hdr_ready),
        .i_seg_done  (seg_done),
        .o_seq       (seq),
        .o_busy      (busy)
    );

    tcp_seg_builder u_tcp_seg_builder (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_hdr       (hdr),
        .i_hdr_valid (hdr_valid),
        .o_hdr_ready (hdr_ready),
        .i_s_data    (i_s_data),
        .i_s_keep    (i_s_keep),
        .i_s_valid   (i_s_valid),
        .o_s_ready   (o_s_ready),
        .i_s_last    (i_s_last),
        .o_m_data    (o_m_data),
        .o_m_keep    (o_m_keep),
        .o_m_valid   (o_m_valid),
        .i_m_ready   (i_m_ready),
        .o_m_last    (o_m_last),
        .o_ip_len    (o_ip_len),
        .o_seg_done  (seg_done)
    );

endmodule

`default_nettype wire

/* test/tcp_tx_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module tcp_tx_tb;

    // words per test, 5 header words plus payload
    localparam int SEG_WORDS   = 5 + 21 + 5 + 5 + 3 * 21 + 5;
    localparam int STALL       = 8;
    localparam int REG_OPS     = 40;
    localparam int CYCLE_LIMIT = SEG_WORDS * STALL + REG_OPS * 6 + 200;

    logic               i_clk = 1'b0;
    logic               i_rst;
    tcp_tx_pkg::addr_t  i_awaddr;
    logic               i_awvalid;
    logic               o_awready;
    tcp_tx_pkg::word_t  i_wdata;
    logic               i_wvalid;
    logic               o_wready;
    logic               o_bvalid;
    logic               i_bready;
    tcp_tx_pkg::addr_t  i_araddr;
    logic               i_arvalid;
    logic               o_arready;
    tcp_tx_pkg::word_t  o_rdata;
    logic               o_rvalid;
    logic               i_rready;
    tcp_tx_pkg::word_t  i_s_data;
    logic [3:0]         i_s_keep;
    logic               i_s_valid;
    logic               o_s_ready;
    logic               i_s_last;
    tcp_tx_pkg::len_t   i_s_len;
    tcp_tx_pkg::word_t  o_m_data;
    logic [3:0]         o_m_keep;
    logic               o_m_valid;
    logic               i_m_ready = 1'b1;
    logic               o_m_last;
    tcp_tx_pkg::len_t   o_ip_len;

    // reference model state
    tcp_tx_pkg::word_t  exp_data [0:511];
    logic               exp_last [0:511];
    tcp_tx_pkg::len_t   exp_ip [0:511];
    logic [8:0]         exp_cnt = '0;
    logic [8:0]         out_idx = '0;
    tcp_tx_pkg::word_t  cur_data;
    logic               cur_last;
    tcp_tx_pkg::len_t   cur_ip;
    tcp_tx_pkg::word_t  pay [0:15];
    tcp_tx_pkg::port_t  cfg_src;
    tcp_tx_pkg::port_t  cfg_dst;
    tcp_tx_pkg::seq_t   cfg_ack;
    tcp_tx_pkg::len_t   cfg_win;
    tcp_tx_pkg::seq_t   exp_seq;

    integer             seed = 32'he82bf149;
    bit                 stall_en = 1'b0;
    int                 err_cnt = 0;
    int                 tests_run = 0;
    int                 tests_failed = 0;
    int                 cycle_cnt = 0;
    int                 err_start;
    int                 nwords;

    tcp_tx_top u_tcp_tx_top (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_awaddr  (i_awaddr),
        .i_awvalid (i_awvalid),
        .o_awready (o_awready),
        .i_wdata   (i_wdata),
        .i_wvalid  (i_wvalid),
        .o_wready  (o_wready),
        .o_bvalid  (o_bvalid),
        .i_bready  (i_bready),
        .i_araddr  (i_araddr),
        .i_arvalid (i_arvalid),
        .o_arready (o_arready),
        .o_rdata   (o_rdata),
        .o_rvalid  (o_rvalid),
        .i_rready  (i_rready),
        .i_s_data  (i_s_data),
        .i_s_keep  (i_s_keep),
        .i_s_valid (i_s_valid),
        .o_s_ready (o_s_ready),
        .i_s_last  (i_s_last),
        .i_s_len   (i_s_len),
        .o_m_data  (o_m_data),
        .o_m_keep  (o_m_keep),
        .o_m_valid (o_m_valid),
        .i_m_ready (i_m_ready),
        .o_m_last  (o_m_last),
        .o_ip_len  (o_ip_len)
    );

    initial begin
        forever #10 i_clk = ~i_clk;
    end

    // #####################################################################
    // output checking
    // #####################################################################
    assign cur_data = exp_data[out_idx];
    assign cur_last = exp_last[out_idx];
    assign cur_ip   = exp_ip[out_idx];

    always @(posedge i_clk) begin
        if (!i_rst && o_m_valid && i_m_ready) begin
            out_idx <= out_idx + 9'd1;
        end
    end

    // random back-pressure only while stall_en is set
    always @(negedge i_clk) begin
        if (stall_en) begin
            i_m_ready = ({$random(seed)} % 4) != 0;
        end else begin
            i_m_ready = 1'b1;
        end
    end

    a_in_list: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_m_valid && i_m_ready) |-> (out_idx != exp_cnt))
    else begin
        $display("[FAIL] t=%0t output word accepted when none was expected", $time);
        err_cnt++;
    end

    a_data: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_m_valid && i_m_ready) |-> (o_m_data == cur_data))
    else begin
        $display("[FAIL] t=%0t o_m_data got %h exp %h", $time,
                 $sampled(o_m_data), $sampled(cur_data));
        err_cnt++;
    end

    // full words only, header and payload alike
    a_keep: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_m_valid && i_m_ready) |-> (o_m_keep == 4'hf))
    else begin
        $display("[FAIL] t=%0t o_m_keep got %h exp f", $time, $sampled(o_m_keep));
        err_cnt++;
    end

    a_last: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_m_valid && i_m_ready) |-> (o_m_last == cur_last))
    else begin
        $display("[FAIL] t=%0t o_m_last got %b exp %b", $time,
                 $sampled(o_m_last), $sampled(cur_last));
        err_cnt++;
    end

    a_ip_len: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_m_valid && i_m_ready) |-> (o_ip_len == cur_ip))
    else begin
        $display("[FAIL] t=%0t o_ip_len got %0d exp %0d", $time,
                 $sampled(o_ip_len), $sampled(cur_ip));
        err_cnt++;
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, a test stopped making progress", cycle_cnt);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // #####################################################################
    // register port
    // #####################################################################
    task automatic reg_write(input tcp_tx_pkg::addr_t addr, input tcp_tx_pkg::word_t data);
        @(negedge i_clk);
        i_awaddr  = addr;
        i_wdata   = data;
        i_awvalid = 1'b1;
        i_wvalid  = 1'b1;
        #1;
        while (!o_awready) begin
            @(negedge i_clk);
            #1;
        end
        // address and data ready rise together
        assert (o_wready) else begin
            $display("[FAIL] t=%0t o_wready got %b exp 1", $time, o_wready);
            err_cnt++;
        end
        @(negedge i_clk);
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
        while (!o_bvalid) begin
            @(negedge i_clk);
        end
    endtask

    task automatic reg_read(input tcp_tx_pkg::addr_t addr, output tcp_tx_pkg::word_t data);
        @(negedge i_clk);
        i_araddr  = addr;
        i_arvalid = 1'b1;
        #1;
        while (!o_arready) begin
            @(negedge i_clk);
            #1;
        end
        @(negedge i_clk);
        i_arvalid = 1'b0;
        while (!o_rvalid) begin
            @(negedge i_clk);
        end
        data = o_rdata;
    endtask

    task automatic check_reg(input tcp_tx_pkg::addr_t addr, input tcp_tx_pkg::word_t exp,
                             input string name);
        tcp_tx_pkg::word_t got;
        reg_read(addr, got);
        assert (got == exp) else begin
            $display("[FAIL] t=%0t %s got %h exp %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic expect_low(input logic value, input string name);
        assert (value == 1'b0) else begin
            $display("[FAIL] t=%0t %s got %b exp 0", $time, name, value);
            err_cnt++;
        end
    endtask

    // #####################################################################
    // reference model
    // #####################################################################
    task automatic push_word(input tcp_tx_pkg::word_t data, input logic last,
                             input tcp_tx_pkg::len_t ip);
        exp_data[exp_cnt] = data;
        exp_last[exp_cnt] = last;
        exp_ip[exp_cnt]   = ip;
        exp_cnt           = exp_cnt + 9'd1;
    endtask

    // ports, seq, ack, offset/flags/window, checksum and urgent as zero
    task automatic expect_header(input tcp_tx_pkg::flags_t flags, input tcp_tx_pkg::len_t nbytes);
        tcp_tx_pkg::len_t ip;
        ip = 16'd40 + nbytes;
        push_word({cfg_src, cfg_dst}, 1'b0, ip);
        push_word(exp_seq, 1'b0, ip);
        push_word(cfg_ack, 1'b0, ip);
        push_word({8'h50, flags, cfg_win}, 1'b0, ip);
        push_word(32'h0, nbytes == 16'd0, ip);
    endtask

    task automatic wait_words();
        while (out_idx != exp_cnt) begin
            @(negedge i_clk);
        end
    endtask

    task automatic drive_payload(input int count);
        int i;
        @(negedge i_clk);
        i_s_len = tcp_tx_pkg::len_t'(count * 4);
        i = 0;
        while (i < count) begin
            i_s_data  = pay[i];
            i_s_keep  = 4'hf;
            i_s_valid = 1'b1;
            i_s_last  = (i == count - 1);
            #1;
            // taken at the coming rising edge
            if (o_s_ready) begin
                i++;
            end
            @(negedge i_clk);
        end
        i_s_valid = 1'b0;
        i_s_last  = 1'b0;
    endtask

    task automatic run_cmd(input tcp_tx_pkg::word_t code, input tcp_tx_pkg::flags_t flags,
                           input tcp_tx_pkg::seq_t inc);
        expect_header(flags, 16'd0);
        reg_write(tcp_tx_pkg::REG_CMD, code);
        wait_words();
        exp_seq = exp_seq + inc;
        check_reg(tcp_tx_pkg::REG_SEQ, exp_seq, "REG_SEQ");
        check_reg(tcp_tx_pkg::REG_STATUS, 32'h0, "REG_STATUS");
    endtask

    task automatic run_data(input int count);
        for (int i = 0; i < count; i++) begin
            pay[i] = $random(seed);
        end
        expect_header(8'h18, tcp_tx_pkg::len_t'(count * 4));
        for (int i = 0; i < count; i++) begin
            push_word(pay[i], i == count - 1, tcp_tx_pkg::len_t'(40 + count * 4));
        end
        drive_payload(count);
        wait_words();
        exp_seq = exp_seq + tcp_tx_pkg::seq_t'(count * 4);
        check_reg(tcp_tx_pkg::REG_SEQ, exp_seq, "REG_SEQ");
    endtask

    task automatic report_test(input string name, input int start);
        tests_run++;
        if (err_cnt == start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, err_cnt - start);
        end
    endtask

    // #####################################################################
    // test sequence
    // #####################################################################
    initial begin
        i_rst     = 1'b1;
        i_awaddr  = '0;
        i_awvalid = 1'b0;
        i_wdata   = '0;
        i_wvalid  = 1'b0;
        i_bready  = 1'b1;
        i_araddr  = '0;
        i_arvalid = 1'b0;
        i_rready  = 1'b1;
        i_s_data  = '0;
        i_s_keep  = '0;
        i_s_valid = 1'b0;
        i_s_last  = 1'b0;
        i_s_len   = '0;
        exp_seq   = '0;
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;

        err_start = err_cnt;
        expect_low(o_bvalid, "o_bvalid");
        expect_low(o_rvalid, "o_rvalid");
        expect_low(o_m_valid, "o_m_valid");
        expect_low(o_s_ready, "o_s_ready");
        check_reg(tcp_tx_pkg::REG_SEQ, 32'h0, "REG_SEQ");
        check_reg(tcp_tx_pkg::REG_STATUS, 32'h0, "REG_STATUS");
        report_test("reset state", err_start);

        err_start = err_cnt;
        cfg_src = 16'hc350;
        cfg_dst = 16'h0050;
        cfg_ack = 32'h1a2b3c4d;
        cfg_win = 16'hfaf0;
        reg_write(tcp_tx_pkg::REG_PORTS, {cfg_src, cfg_dst});
        reg_write(tcp_tx_pkg::REG_ACK, cfg_ack);
        reg_write(tcp_tx_pkg::REG_WINDOW, {16'd0, cfg_win});
        check_reg(tcp_tx_pkg::REG_PORTS, {cfg_src, cfg_dst}, "REG_PORTS");
        check_reg(tcp_tx_pkg::REG_ACK, cfg_ack, "REG_ACK");
        check_reg(tcp_tx_pkg::REG_WINDOW, {16'd0, cfg_win}, "REG_WINDOW");
        check_reg(8'h20, 32'h0, "unmapped read");
        report_test("register readback", err_start);

        err_start = err_cnt;
        run_cmd(32'd0, 8'h02, 32'd1);
        report_test("syn segment", err_start);

        err_start = err_cnt;
        nwords = 1 + ({$random(seed)} % 16);
        run_data(nwords);
        report_test("data segment", err_start);

        err_start = err_cnt;
        run_cmd(32'd1, 8'h10, 32'd0);
        run_cmd(32'd2, 8'h11, 32'd1);
        report_test("ack and fin", err_start);

        err_start = err_cnt;
        stall_en = 1'b1;
        run_data(1 + ({$random(seed)} % 16));
        run_cmd(32'd1, 8'h10, 32'd0);
        run_data(1 + ({$random(seed)} % 16));
        run_data(16);
        stall_en = 1'b0;
        repeat (4) @(negedge i_clk);
        expect_low(o_m_valid, "o_m_valid");
        assert (out_idx == exp_cnt) else begin
            $display("output word count does not match the expected word list");
            err_cnt++;
        end
        report_test("back-pressure", err_start);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
hdl/tcp_tx_pkg.sv
hdl/tcp_cmd_decode.sv
hdl/tcp_tx_ctrl.sv
hdl/tcp_seg_builder.sv
hdl/tcp_tx_top.sv
test/tcp_tx_tb.sv

/* sim.sh */
#!/bin/sh
# build the tcp transmit testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -j 0 \
        --top-module tcp_tx_tb -f filelist.f -o Vtcp_tx_tb; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtcp_tx_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation PASSED" "$LOG"; then
    exit 0
fi

echo "pass message not found in $LOG"
exit 1
